/* hdl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	localparam int LINE_BITS = 256;
	localparam int WORD_BITS = 32;
	localparam int OFFSET_BITS = 5;

	typedef logic [LINE_BITS-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [31:0] addr;		// byte address
		logic [WORD_BITS-1:0] wdata;
		logic [WORD_BITS/8-1:0] be;
	} cpu_req_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [31:0] addr;
		logic [WORD_BITS-1:0] wdata;
		logic [WORD_BITS/8-1:0] be;
		logic hit;
		logic way;			// hit way, or filled way after a miss
	} stage_t;

	typedef enum logic [2:0] {
		MEM_IDLE,
		MEM_WB_REQ,
		MEM_WB_REL,
		MEM_FILL_REQ,
		MEM_FILL_REL,
		MEM_DONE
	} mem_state_t;

endpackage

`default_nettype wire

/* hdl/cache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array #(
	parameter int SETS = 8
) (
	input logic clk,
	input logic rst,
	input logic [31:0] lookup_addr_i,
	output logic hit_o,
	output logic hit_way_o,
	input logic [31:0] upd_addr_i,
	input logic touch_i,
	input logic touch_way_i,
	input logic set_dirty_i,
	input logic fill_en_i,
	input logic fill_way_i,
	output logic victim_way_o,
	output logic victim_dirty_o,
	output logic [31:cache_pkg::OFFSET_BITS] victim_tag_o
);

	localparam int SET_BITS = $clog2(SETS);

	logic [31:cache_pkg::OFFSET_BITS] tag_q [SETS][2];
	logic [1:0] valid_q [SETS];
	logic [1:0] dirty_q [SETS];
	logic [SETS-1:0] lru_q;		// way to replace next
	logic [SET_BITS-1:0] lookup_set;
	logic [SET_BITS-1:0] upd_set;
	logic [1:0] way_hit;

	assign lookup_set = lookup_addr_i[cache_pkg::OFFSET_BITS +: SET_BITS];
	assign upd_set = upd_addr_i[cache_pkg::OFFSET_BITS +: SET_BITS];

	always_comb
	begin
		for (int w = 0; w < 2; w++)
			way_hit[w] = valid_q[lookup_set][w] &&
				(tag_q[lookup_set][w] == lookup_addr_i[31:cache_pkg::OFFSET_BITS]);
		hit_o = |way_hit;
		hit_way_o = way_hit[1];
	end

	always_comb
	begin
		if (!valid_q[upd_set][0])
			victim_way_o = 1'b0;	// empty way first
		else if (!valid_q[upd_set][1])
			victim_way_o = 1'b1;
		else
			victim_way_o = lru_q[upd_set];
		victim_dirty_o = valid_q[upd_set][victim_way_o] && dirty_q[upd_set][victim_way_o];
		victim_tag_o = tag_q[upd_set][victim_way_o];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < SETS; s++)
			begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				tag_q[s][0] <= '0;
				tag_q[s][1] <= '0;
			end
			lru_q <= '0;
		end
		else if (fill_en_i)
		begin
			tag_q[upd_set][fill_way_i] <= upd_addr_i[31:cache_pkg::OFFSET_BITS];
			valid_q[upd_set][fill_way_i] <= 1'b1;
			dirty_q[upd_set][fill_way_i] <= 1'b0;	// installed clean
			lru_q[upd_set] <= ~fill_way_i;
		end
		else if (touch_i)
		begin
			lru_q[upd_set] <= ~touch_way_i;
			if (set_dirty_i)
				dirty_q[upd_set][touch_way_i] <= 1'b1;
		end
	end

	a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
		!(way_hit[0] && way_hit[1]))
		else $error("tag match in both ways of set %0d", lookup_set);

endmodule

`default_nettype wire

/* hdl/cache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_array #(
	parameter int SETS = 8
) (
	input logic clk,
	input logic [31:0] addr_i,
	input logic way_i,
	input logic [cache_pkg::WORD_BITS-1:0] wdata_i,
	input logic [cache_pkg::WORD_BITS/8-1:0] be_i,
	input logic write_en_i,
	input logic fill_en_i,
	input cache_pkg::line_t fill_line_i,
	output logic [cache_pkg::WORD_BITS-1:0] rdata_o,
	output cache_pkg::line_t victim_line_o
);

	localparam int SET_BITS = $clog2(SETS);
	localparam int WORD_SEL_BITS = $clog2(cache_pkg::LINE_BITS / cache_pkg::WORD_BITS);

	cache_pkg::line_t line_q [SETS][2];
	logic [SET_BITS-1:0] set_idx;
	logic [WORD_SEL_BITS-1:0] word_idx;

	assign set_idx = addr_i[cache_pkg::OFFSET_BITS +: SET_BITS];
	assign word_idx = addr_i[cache_pkg::OFFSET_BITS-1 -: WORD_SEL_BITS];

	// whole line doubles as the write-back source
	assign victim_line_o = line_q[set_idx][way_i];
	assign rdata_o = victim_line_o[word_idx*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];

	always_ff @(posedge clk)
	begin
		if (fill_en_i)
			line_q[set_idx][way_i] <= fill_line_i;
		else if (write_en_i)
		begin
			for (int b = 0; b < cache_pkg::WORD_BITS/8; b++)
			begin
				if (be_i[b])
					line_q[set_idx][way_i][word_idx*cache_pkg::WORD_BITS + b*8 +: 8] <=
						wdata_i[b*8 +: 8];	// enabled bytes only
			end
		end
	end

	a_no_write_on_fill: assert property (@(posedge clk)
		!(write_en_i && fill_en_i))
		else $error("cpu write collides with line fill");

endmodule

`default_nettype wire

/* hdl/cache_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_stage_reg (
	input logic clk,
	input logic rst,
	input cache_pkg::cpu_req_t req_i,
	input logic hit_i,
	input logic hit_way_i,
	input logic stall_i,
	input logic fill_done_i,
	input logic fill_way_i,
	output cache_pkg::stage_t stage_o
);

	cache_pkg::stage_t stage_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			stage_q <= '0;
		else if (fill_done_i)
		begin
			// line is now resident, so the held request retires as a hit
			stage_q.hit <= 1'b1;
			stage_q.way <= fill_way_i;
		end
		else if (!stall_i)
		begin
			if (req_i.valid)
			begin
				stage_q.valid <= 1'b1;
				stage_q.write <= req_i.write;
				stage_q.addr <= req_i.addr;
				stage_q.wdata <= req_i.wdata;
				stage_q.be <= req_i.be;
				stage_q.hit <= hit_i;
				stage_q.way <= hit_way_i;
			end
			else
			begin
				stage_q.valid <= 1'b0;	// bubble
				stage_q.hit <= 1'b0;
			end
		end
	end

	assign stage_o = stage_q;

	a_fill_done_on_miss: assert property (@(posedge clk) disable iff (rst)
		fill_done_i |-> (stall_i && stage_o.valid && !stage_o.hit))
		else $error("fill_done_i without a held miss in stage 2");

endmodule

`default_nettype wire

/* hdl/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_control #(
	parameter int SETS = 8
) (
	input logic clk,
	input logic rst,
	input cache_pkg::stage_t stage_i,
	input logic victim_way_i,
	input logic victim_dirty_i,
	input logic [31:cache_pkg::OFFSET_BITS] victim_tag_i,
	input cache_pkg::line_t victim_line_i,
	output logic stall_o,
	output logic fill_en_o,
	output logic fill_way_o,
	output logic fill_done_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [31:cache_pkg::OFFSET_BITS] mem_addr_o,
	output cache_pkg::line_t mem_wdata_o,
	input cache_pkg::line_t mem_rdata_i,
	input logic mem_ack_i,
	output cache_pkg::line_t fill_line_o
);

	cache_pkg::mem_state_t state_q;
	cache_pkg::mem_state_t state_d;
	logic miss;
	logic way_q;
	cache_pkg::line_t line_q;

	if (SETS < 2 || (SETS & (SETS - 1)) != 0)
	begin : g_bad_sets
		$error("SETS must be a power of two of at least 2");
	end

	assign miss = stage_i.valid && !stage_i.hit;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			cache_pkg::MEM_IDLE:
				if (miss)
					state_d = victim_dirty_i ? cache_pkg::MEM_WB_REQ : cache_pkg::MEM_FILL_REQ;
			cache_pkg::MEM_WB_REQ:
				if (mem_ack_i)
					state_d = cache_pkg::MEM_WB_REL;
			cache_pkg::MEM_WB_REL:
				if (!mem_ack_i)
					state_d = cache_pkg::MEM_FILL_REQ;
			cache_pkg::MEM_FILL_REQ:
				if (mem_ack_i)
					state_d = cache_pkg::MEM_FILL_REL;
			cache_pkg::MEM_FILL_REL:
				if (!mem_ack_i)
					state_d = cache_pkg::MEM_DONE;
			cache_pkg::MEM_DONE:
				state_d = cache_pkg::MEM_IDLE;
			default:
				state_d = cache_pkg::MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state_q <= cache_pkg::MEM_IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk)
	begin
		if (state_q == cache_pkg::MEM_IDLE && miss)
			way_q <= victim_way_i;	// victim stays put for the whole miss
		if (state_q == cache_pkg::MEM_FILL_REQ && mem_ack_i)
			line_q <= mem_rdata_i;
	end

	assign stall_o = (state_q != cache_pkg::MEM_IDLE) || miss;
	assign fill_en_o = (state_q == cache_pkg::MEM_FILL_REL) && !mem_ack_i;
	assign fill_way_o = way_q;
	assign fill_done_o = (state_q == cache_pkg::MEM_DONE);
	assign fill_line_o = line_q;

	assign mem_req_o = (state_q == cache_pkg::MEM_WB_REQ) || (state_q == cache_pkg::MEM_FILL_REQ);
	assign mem_we_o = (state_q == cache_pkg::MEM_WB_REQ);
	assign mem_addr_o = (state_q == cache_pkg::MEM_WB_REQ || state_q == cache_pkg::MEM_WB_REL) ?
		victim_tag_i : stage_i.addr[31:cache_pkg::OFFSET_BITS];
	assign mem_wdata_o = victim_line_i;

	a_req_held_to_ack: assert property (@(posedge clk) disable iff (rst)
		(mem_req_o && !mem_ack_i) |=>
			(mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)))
		else $error("memory request dropped or changed before mem_ack_i");

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
	parameter int SETS = 8
) (
	input logic clk,
	input logic rst,
	input cache_pkg::cpu_req_t cpu_req_i,
	output logic stall_o,
	output logic resp_valid_o,
	output logic [cache_pkg::WORD_BITS-1:0] rdata_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [31:cache_pkg::OFFSET_BITS] mem_addr_o,
	output cache_pkg::line_t mem_wdata_o,
	input cache_pkg::line_t mem_rdata_i,
	input logic mem_ack_i
);

	cache_pkg::stage_t stage;
	cache_pkg::line_t fill_line;
	cache_pkg::line_t victim_line;
	logic [31:cache_pkg::OFFSET_BITS] victim_tag;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic fill_en;
	logic fill_way;
	logic fill_done;
	logic write_en;
	logic data_way;

	assign resp_valid_o = stage.valid && stage.hit && !stall_o;
	assign write_en = resp_valid_o && stage.write;
	assign data_way = stall_o ? fill_way : stage.way;	// victim/fill way during a miss

	cache_tag_array #(.SETS(SETS)) cache_tag_array_inst (
		.clk(clk), .rst(rst),
		.lookup_addr_i(cpu_req_i.addr), .hit_o(hit), .hit_way_o(hit_way),
		.upd_addr_i(stage.addr), .touch_i(resp_valid_o), .touch_way_i(stage.way),
		.set_dirty_i(write_en), .fill_en_i(fill_en), .fill_way_i(fill_way),
		.victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
	);

	cache_data_array #(.SETS(SETS)) cache_data_array_inst (
		.clk(clk), .addr_i(stage.addr), .way_i(data_way),
		.wdata_i(stage.wdata), .be_i(stage.be), .write_en_i(write_en),
		.fill_en_i(fill_en), .fill_line_i(fill_line),
		.rdata_o(rdata_o), .victim_line_o(victim_line)
	);

	cache_stage_reg cache_stage_reg_inst (
		.clk(clk), .rst(rst), .req_i(cpu_req_i), .hit_i(hit), .hit_way_i(hit_way),
		.stall_i(stall_o), .fill_done_i(fill_done), .fill_way_i(fill_way), .stage_o(stage)
	);

	cache_control #(.SETS(SETS)) cache_control_inst (
		.clk(clk), .rst(rst), .stage_i(stage),
		.victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
		.victim_tag_i(victim_tag), .victim_line_i(victim_line),
		.stall_o(stall_o), .fill_en_o(fill_en), .fill_way_o(fill_way), .fill_done_o(fill_done),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i),
		.fill_line_o(fill_line)
	);

	// a completed fill must retire the held request on the very next cycle
	a_done_then_resp: assert property (@(posedge clk) disable iff (rst)
		(cache_control_inst.state_q == cache_pkg::MEM_DONE) |=> resp_valid_o)
		else $error("no response after fill for addr %h", stage.addr);

endmodule

`default_nettype wire

/* verification/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	localparam int SETS = 8;
	localparam int N_RANDOM = 300;
	localparam int TOTAL_REQS = 21 + N_RANDOM;
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * 40 + 200;
	localparam logic [31:0] SET_STRIDE = 32'(SETS * 32);	// same set, next tag

	typedef struct packed {
		logic write;
		logic timed;		// response due one cycle after acceptance
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] cycle;
	} expect_t;

	logic clk;
	logic rst;
	cache_pkg::cpu_req_t cpu_req;
	logic stall;
	logic resp_valid;
	logic [31:0] rdata;
	logic mem_req;
	logic mem_we;
	logic [31:cache_pkg::OFFSET_BITS] mem_addr;
	cache_pkg::line_t mem_wdata;
	cache_pkg::line_t mem_rdata;
	logic mem_ack;

	logic [31:0] cycle = '0;
	logic [31:0] shadow [512];
	cache_pkg::line_t mem_lines [64];
	expect_t exp_q [$];
	int errors = 0;
	int checked = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int fills = 0;
	int wbs = 0;

	cache_top #(.SETS(SETS)) cache_top_inst (
		.clk(clk), .rst(rst), .cpu_req_i(cpu_req), .stall_o(stall), .resp_valid_o(resp_valid),
		.rdata_o(rdata), .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
		input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (be[b])
				res[b*8 +: 8] = wdata[b*8 +: 8];
		return res;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return shadow[addr[10:2]];
	endfunction

	task automatic check_value(input string name, input int got, input int want);
		assert (got == want)
		else
		begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, want);
		end
	endtask

	// holds the request until the cache takes it
	task automatic issue(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] be, input logic timed);
		expect_t e;
		cpu_req.valid = 1'b1;
		cpu_req.write = write;
		cpu_req.addr = addr;
		cpu_req.wdata = wdata;
		cpu_req.be = be;
		while (stall)
			@(negedge clk);
		if (write)
			shadow[addr[10:2]] = merge_bytes(shadow[addr[10:2]], wdata, be);
		e.write = write;
		e.timed = timed;
		e.addr = addr;
		e.data = expected_word(addr);
		e.cycle = cycle;
		exp_q.push_back(e);
		@(negedge clk);	// accepted on the edge in between
	endtask

	task automatic drain();
		cpu_req.valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial
	begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, %0d responses outstanding", cycle, exp_q.size());
		$display("TEST FAILED");
		$finish;
	end

	// memory side of the four-phase handshake
	initial
	begin
		logic [31:0] rng;
		logic [5:0] idx;
		rng = 32'h60f1;
		mem_ack = 1'b0;
		mem_rdata = '0;
		for (int l = 0; l < 64; l++)
			for (int w = 0; w < 8; w++)
				mem_lines[l][w*32 +: 32] = fill_word(32'(l * 32 + w * 4));
		forever
		begin
			@(negedge clk);
			if (!rst && mem_req && !mem_ack)
			begin
				rng = xorshift(rng);
				repeat (rng[2:0])
					@(negedge clk);
				idx = mem_addr[10:5];
				if (mem_we)
				begin
					mem_lines[idx] = mem_wdata;
					wbs++;
				end
				else
				begin
					mem_rdata = mem_lines[idx];
					fills++;
				end
				mem_ack = 1'b1;
				@(negedge clk);
				while (mem_req)
					@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	always @(negedge clk)
	begin
		expect_t e;
		if (!rst && resp_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				errors++;
				$display("response arrived with no request outstanding");
			end
			if (exp_q.size() != 0)
			begin
				e = exp_q.pop_front();
				checked++;
				if (!e.write)
				begin
					assert (rdata == e.data)
					else
					begin
						errors++;
						$display("** Error: rdata_o = %h, expected %h (addr %h)", rdata, e.data, e.addr);
					end
				end
				if (e.timed)
				begin
					assert (cycle == e.cycle + 1)
					else
					begin
						errors++;
						$display("response for addr %h came %0d cycles after acceptance, not 1",
							e.addr, cycle - e.cycle);
					end
				end
			end
		end
	end

	initial
	begin
		logic [31:0] rng;
		logic [31:0] wdata;
		int err_before;
		int wb_before;
		rst = 1'b1;
		cpu_req = '0;
		rng = 32'h60f1;
		for (int i = 0; i < 512; i++)
			shadow[i] = fill_word(32'(i * 4));
		repeat (5)
			@(negedge clk);
		rst = 1'b0;

		err_before = errors;
		check_value("stall_o", int'(stall), 0);
		check_value("resp_valid_o", int'(resp_valid), 0);
		check_value("mem_req_o", int'(mem_req), 0);
		issue(1'b0, 32'h000, '0, '0, 1'b0);
		drain();
		check_value("line fills", fills, 1);
		check_value("write-backs", wbs, 0);
		end_test("reset and first miss", err_before);

		err_before = errors;
		for (int i = 0; i < 8; i++)
			issue(1'b0, 32'(i * 4), '0, '0, 1'b1);
		drain();
		end_test("hit latency", err_before);

		err_before = errors;
		issue(1'b1, 32'h008, 32'hdead_beef, 4'b0101, 1'b0);
		issue(1'b1, 32'h008, 32'h1122_3344, 4'b1000, 1'b0);
		issue(1'b1, 32'h044, 32'hcafe_f00d, 4'b0011, 1'b0);	// write miss
		issue(1'b1, 32'h00c, 32'h0bad_cafe, 4'b1111, 1'b0);
		issue(1'b0, 32'h00c, '0, '0, 1'b1);	// read right behind the write
		issue(1'b0, 32'h008, '0, '0, 1'b0);
		issue(1'b0, 32'h044, '0, '0, 1'b0);
		issue(1'b0, 32'h040, '0, '0, 1'b0);
		drain();
		end_test("byte-enable writes", err_before);

		err_before = errors;
		wb_before = wbs;
		issue(1'b1, SET_STRIDE + 32'h4, 32'h7777_aaaa, 4'b1111, 1'b0);
		issue(1'b0, 2 * SET_STRIDE, '0, '0, 1'b0);
		issue(1'b0, 32'h008, '0, '0, 1'b0);	// dirty line back from memory
		issue(1'b0, SET_STRIDE + 32'h4, '0, '0, 1'b0);
		drain();
		check_value("write-backs", wbs - wb_before, 2);
		end_test("dirty eviction", err_before);

		err_before = errors;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			rng = xorshift(rng);
			wdata = xorshift(rng ^ 32'h9e37_79b9);
			issue(rng[31], {22'd0, rng[9:2], 2'b00}, wdata, rng[15:12], 1'b0);
			if (rng[20:18] == 3'd0)
			begin
				cpu_req.valid = 1'b0;	// idle cycle now and then
				@(negedge clk);
			end
		end
		drain();
		end_test("random mix", err_before);

		$display("%0d tests run, %0d failed, %0d responses checked, %0d errors",
			tests_run, tests_failed, checked, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_stage_reg.sv
hdl/cache_control.sv
hdl/cache_top.sv
verification/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module cache_tb \
	-Mdir "$BUILD_DIR" -o cache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/cache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
